//--- test/memTests.txt
# Kinds: F byte | R op reg addr data | E reg data | S cycles or r | G cycles
# Hex values; S and G counts are decimal, S r draws a random stall
F 34
F 12
F 78
F 56
F cd
F ab
F 01
F ef
R 1 1 0000 0000
E 1 1234
R 1 2 0006 0000
E 2 ef01
R 0 3 0002 0000
E 3 0078
R 0 4 0005 0000
E 4 00ab
R 4 0 0003 00c3
R 1 5 0002 0000
E 5 c378
R 5 0 0000 beef
R 1 6 0000 0000
E 6 beef
S 4
R 0 7 0001 0000
E 7 00be
S r
R 1 8 0004 0000
E 8 abcd
R 4 0 0006 1142
S r
R 0 9 0006 0000
E 9 0042
S r
R 0 a 0007 0000
E a 00ef
# Loads without gaps, then the same loads with clock-enable gaps
R 1 1 0002 0000
E 1 c378
R 0 2 0001 0000
E 2 00be
R 1 3 0006 0000
E 3 ef42
G 3
R 1 1 0002 0000
G 2
E 1 c378
S 3
R 0 2 0001 0000
G 4
E 2 00be
R 1 3 0006 0000
E 3 ef42
G 2

//--- filelist.f
source/memPkg.sv
source/dataMemory.sv
source/flashProgrammer.sv
source/loadStoreUnit.sv
source/memorySubsystem.sv
test/clockGen.sv
test/memorySubsystemTb.sv

//--- Makefile
# Verilator lint, build and run of the memory subsystem testbench

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= memorySubsystemTb
RTL_TOP   ?= memorySubsystem
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_TEXT ?= Test completed successfully

SOURCES     := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter source/%,$(SOURCES))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/memorySubsystemTb.sv
`timescale 1ns/1ps

module memorySubsystemTb;
    import memPkg::*;

    localparam int memDepth = 256;

    logic     clk;
    logic     rstN;
    logic     clkEn;
    logic     flashEn;
    logic     flashValid;
    logic [7:0] flashByte;
    lsRequest request;
    logic     loadStoreAck;
    logic     writebackReq;
    logic     loadStoreReq;
    logic     writebackAck;
    wbResult  result;

    string   lines[$];          // Command lines of the tests file
    wbResult expected[$];       // Load results in writeback order
    int      watchCycles;
    int      stallLeft;         // Cycles the current load is still held
    int      nextStall;         // Hold for the next accepted load
    logic    flashing;
    logic    gapActive;
    logic    gapFirst;
    logic    acceptNow;
    logic    accepted;
    logic    reqIsStore;
    logic    gapLsReq;
    logic    gapWbAck;
    wbResult gapResult;

    clockGen clockGen0 (
        .clk  (clk),
        .rstN (rstN)
    );

    memorySubsystem #(
        .memDepth (memDepth)
    ) dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .clkEn        (clkEn),
        .flashEn      (flashEn),
        .flashValid   (flashValid),
        .flashByte    (flashByte),
        .request      (request),
        .loadStoreAck (loadStoreAck),
        .writebackReq (writebackReq),
        .loadStoreReq (loadStoreReq),
        .writebackAck (writebackAck),
        .result       (result)
    );

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] want);
        if (actual !== want) begin
            $display("FAILED %s: got %h, expected %h", name, actual, want);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("ERROR: %s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    // Transfer happens on the coming edge, so the result is checked now
    task automatic checkTransfer();
        wbResult want;
        if (expected.size() == 0) begin
            abortRun("a load result was handed over when none was expected");
        end else begin
            want = expected.pop_front();
            checkValue("result.destReg", 16'(result.destReg), 16'(want.destReg));
            checkValue("result.data", result.data, want.data);
        end
    endtask

    // Outputs must hold still while clkEn is low
    task automatic checkFrozen();
        if (gapFirst) begin
            gapLsReq  = loadStoreReq;
            gapWbAck  = writebackAck;
            gapResult = result;
            gapFirst  = 1'b0;
        end else begin
            checkValue("loadStoreReq", 16'(loadStoreReq), 16'(gapLsReq));
            checkValue("writebackAck", 16'(writebackAck), 16'(gapWbAck));
            checkValue("result.destReg", 16'(result.destReg), 16'(gapResult.destReg));
            checkValue("result.data", result.data, gapResult.data);
        end
    endtask

    // Look at the DUT mid-cycle, then step to the next drive point
    task automatic runCycle();
        @(negedge clk);
        if (flashEn) checkValue("loadStoreReq", 16'(loadStoreReq), 16'h0);
        if (writebackAck && !writebackReq) begin
            checkValue("loadStoreReq", 16'(loadStoreReq), 16'h0);    // Held load blocks issue
        end
        if (gapActive) checkFrozen();
        if (writebackAck && writebackReq && clkEn) checkTransfer();
        acceptNow = loadStoreReq && loadStoreAck && clkEn;
        @(posedge clk);
        #1;
        if (acceptNow) begin
            loadStoreAck = 1'b0;
            accepted     = 1'b1;
            if (!reqIsStore) begin
                stallLeft = nextStall;
                nextStall = 0;
            end
        end
        if (!gapActive) begin
            if (writebackAck && stallLeft > 0) begin
                writebackReq = 1'b0;
                stallLeft--;
            end else begin
                writebackReq = 1'b1;
            end
        end
    endtask

    task automatic sendFlashByte(input logic [7:0] value);
        flashEn    = 1'b1;
        flashing   = 1'b1;
        flashValid = 1'b1;
        flashByte  = value;
        runCycle();
        flashValid = 1'b0;
    endtask

    task automatic endFlash();
        flashEn    = 1'b0;
        flashValid = 1'b0;
        flashing   = 1'b0;
    endtask

    task automatic issueRequest(input logic [3:0] op, input logic [3:0] destReg,
                                input logic [15:0] addr, input logic [15:0] data);
        int delay;
        delay           = $urandom % 3;    // Issue stage is sometimes late
        request.op      = minorOp'(op);
        request.destReg = destReg;
        request.addr    = addr;
        request.data    = data;
        reqIsStore      = op[2];
        repeat (delay) runCycle();
        loadStoreAck = 1'b1;
        accepted     = 1'b0;
        while (!accepted) runCycle();
    endtask

    task automatic clockGap(input int cycles);
        clkEn     = 1'b0;
        gapActive = 1'b1;
        gapFirst  = 1'b1;
        repeat (cycles) runCycle();
        gapActive = 1'b0;
        clkEn     = 1'b1;
    endtask

    initial begin : watchdog
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clk);
        abortRun("watchdog expired, the run hung waiting on a handshake");
    end

    initial begin : mainFlow
        int          fd;
        int          cmdLines;
        int          stallTotal;
        int          n;
        string       line;
        logic [15:0] a, b, c, d;
        wbResult     want;

        clkEn        = 1'b0;
        flashEn      = 1'b0;
        flashValid   = 1'b0;
        flashByte    = 8'h00;
        request      = '0;
        loadStoreAck = 1'b0;
        writebackReq = 1'b1;
        stallLeft    = 0;
        nextStall    = 0;
        flashing     = 1'b0;
        gapActive    = 1'b0;
        gapFirst     = 1'b0;
        acceptNow    = 1'b0;
        accepted     = 1'b0;
        reqIsStore   = 1'b0;
        watchCycles  = 0;
        cmdLines     = 0;
        stallTotal   = 0;
        void'($urandom(26785));

        fd = $fopen("test/memTests.txt", "r");
        if (fd == 0) abortRun("could not open test/memTests.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
                cmdLines++;
                if (line.getc(0) == "S" && line.getc(2) == "r") begin
                    stallTotal += 7;    // Largest random stall
                end else if (line.getc(0) == "S" || line.getc(0) == "G") begin
                    void'($sscanf(line.substr(1, line.len() - 1), "%d", n));
                    stallTotal += n;
                end
            end
        end
        $fclose(fd);
        watchCycles = cmdLines * 40 + stallTotal;

        @(negedge clk);     // Still in reset
        checkValue("loadStoreReq", 16'(loadStoreReq), 16'h0);
        checkValue("writebackAck", 16'(writebackAck), 16'h0);
        wait (rstN === 1'b1);
        repeat (2) begin    // No enabled edge yet
            @(negedge clk);
            checkValue("loadStoreReq", 16'(loadStoreReq), 16'h0);
            checkValue("writebackAck", 16'(writebackAck), 16'h0);
        end
        @(posedge clk);
        #1;
        clkEn = 1'b1;

        foreach (lines[i]) begin
            line = lines[i];
            if (flashing && line.getc(0) != "F") endFlash();
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
            case (line.getc(0))
                "F": sendFlashByte(a[7:0]);
                "R": issueRequest(a[3:0], b[3:0], c, d);
                "E": begin
                    want.destReg = a[3:0];
                    want.data    = b;
                    expected.push_back(want);
                end
                "S": begin
                    if (line.getc(2) == "r") begin
                        nextStall = $urandom % 8;
                    end else begin
                        void'($sscanf(line.substr(1, line.len() - 1), "%d", nextStall));
                    end
                end
                "G": begin
                    void'($sscanf(line.substr(1, line.len() - 1), "%d", n));
                    clockGap(n);
                end
                default: abortRun("the tests file holds a line of unknown kind");
            endcase
        end
        if (flashing) endFlash();

        while (expected.size() > 0) runCycle();
        repeat (3) runCycle();      // Room for a stray extra result

        if (writebackAck == 1'b0 && loadStoreReq == 1'b1) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abortRun("the DUT was not idle and ready for a new request at the end of the run");
        end
    end

endmodule : memorySubsystemTb

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod  = 5,    // 10 ns clock
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;    // Released with the other inputs
    end

endmodule : clockGen

//--- source/memorySubsystem.sv
`timescale 1ns/1ps

module memorySubsystem #(
    parameter int memDepth = 512     // Words of data memory
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             clkEn,
    input  logic             flashEn,
    input  logic             flashValid,
    input  logic [7:0]       flashByte,
    input  memPkg::lsRequest request,
    input  logic             loadStoreAck,
    input  logic             writebackReq,
    output logic             loadStoreReq,
    output logic             writebackAck,
    output memPkg::wbResult  result
);
    import memPkg::*;

    memWrite flashWrite;
    memWrite storeWrite;
    logic    flashBusy;     // Keeps the load/store unit off the memory
    logic    readEn;
    byteAddr readIndex;
    dataWord readWord;

    flashProgrammer flashProgrammer0 (
        .clk        (clk),
        .rstN       (rstN),
        .clkEn      (clkEn),
        .flashEn    (flashEn),
        .flashValid (flashValid),
        .flashByte  (flashByte),
        .flashWrite (flashWrite),
        .flashBusy  (flashBusy)
    );

    dataMemory #(
        .memDepth (memDepth)
    ) dataMemory0 (
        .clk        (clk),
        .clkEn      (clkEn),
        .flashWrite (flashWrite),
        .storeWrite (storeWrite),
        .readEn     (readEn),
        .readIndex  (readIndex),
        .readWord   (readWord)
    );

    loadStoreUnit loadStoreUnit0 (
        .clk          (clk),
        .rstN         (rstN),
        .clkEn        (clkEn),
        .flashBusy    (flashBusy),
        .request      (request),
        .loadStoreAck (loadStoreAck),
        .loadStoreReq (loadStoreReq),
        .writebackReq (writebackReq),
        .writebackAck (writebackAck),
        .result       (result),
        .readEn       (readEn),
        .readIndex    (readIndex),
        .readWord     (readWord),
        .storeWrite   (storeWrite)
    );

endmodule : memorySubsystem

//--- source/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             clkEn,
    input  logic             flashBusy,
    input  memPkg::lsRequest request,
    input  logic             loadStoreAck,
    output logic             loadStoreReq,
    input  logic             writebackReq,
    output logic             writebackAck,
    output memPkg::wbResult  result,
    output logic             readEn,
    output memPkg::byteAddr  readIndex,
    input  memPkg::dataWord  readWord,
    output memPkg::memWrite  storeWrite
);
    import memPkg::*;

    typedef enum logic [1:0] {
        idle,
        loadPending,
        storePending
    } lsState;

    lsState   state;
    lsRequest pending;       // Accepted operation
    logic     started;       // Low until the first enabled edge after reset
    logic     accept;
    logic     wbDone;
    dataWord  storeData;
    dataWord  loadData;

    assign accept = loadStoreReq && loadStoreAck && clkEn;
    assign wbDone = writebackAck && writebackReq && clkEn;

    // A pending load can hand over and take the next op on one edge
    assign loadStoreReq = started && !flashBusy
        && (state == idle || (state == loadPending && writebackReq));

    assign writebackAck = (state == loadPending);

    // Read goes out with the accept and returns one clock later
    assign readEn    = accept;
    assign readIndex = {1'b0, request.addr[15:1]};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= idle;
            started <= 1'b0;
        end else if (clkEn) begin
            started <= 1'b1;
            if (accept) begin
                state <= request.op[2] ? storePending : loadPending;
            end else if (wbDone || state == storePending) begin
                state <= idle;       // Store write lands on this edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pending <= request;
        end
    end

    // Store alignment keeps the untouched byte of the old word
    always_comb begin
        case (pending.op)
            storeWord: storeData = pending.data;
            default: begin
                if (pending.addr[0]) begin
                    storeData = {pending.data[7:0], readWord[7:0]};   // Odd byte
                end else begin
                    storeData = {readWord[15:8], pending.data[7:0]};
                end
            end
        endcase
    end

    // Load alignment with zero-extended bytes
    always_comb begin
        case (pending.op)
            loadWord: loadData = readWord;
            default: begin
                if (pending.addr[0]) begin
                    loadData = {8'h00, readWord[15:8]};
                end else begin
                    loadData = {8'h00, readWord[7:0]};
                end
            end
        endcase
    end

    assign storeWrite.en        = (state == storePending);
    assign storeWrite.wordIndex = {1'b0, pending.addr[15:1]};
    assign storeWrite.data      = storeData;

    assign result.destReg = pending.destReg;   // Valid while writebackAck is high
    assign result.data    = loadData;

    // Issue stage only sends the four memory opcodes
    assert property (@(posedge clk) disable iff (!rstN)
        accept |-> request.op inside {loadByte, loadWord, storeByte, storeWord})
        else $error("loadStoreUnit: undefined opcode %h accepted", request.op);

    // A held load keeps its result until writeback takes it
    assert property (@(posedge clk) disable iff (!rstN)
        writebackAck && !writebackReq |=> writebackAck && $stable(result))
        else $error("loadStoreUnit: held load result changed");

endmodule : loadStoreUnit

//--- source/flashProgrammer.sv
`timescale 1ns/1ps

module flashProgrammer (
    input  logic            clk,
    input  logic            rstN,
    input  logic            clkEn,
    input  logic            flashEn,
    input  logic            flashValid,
    input  logic [7:0]      flashByte,
    output memPkg::memWrite flashWrite,
    output logic            flashBusy
);

    logic        flashEnQ;      // flashEn one enabled cycle back
    logic        bytePhase;     // High once the low byte is held
    logic [7:0]  lowByte;
    logic [15:0] wordIndex;     // Word the next write goes to
    logic        writeEn;
    logic [15:0] writeData;
    logic        restart;
    logic        takeByte;
    logic        highByte;

    assign restart  = flashEn && !flashEnQ;
    assign takeByte = flashEn && flashValid;
    assign highByte = takeByte && bytePhase && !restart;   // Completes a word

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flashEnQ  <= 1'b0;
            bytePhase <= 1'b0;
            wordIndex <= '0;
            writeEn   <= 1'b0;
        end else if (clkEn) begin
            flashEnQ <= flashEn;
            writeEn  <= highByte;      // One-cycle pulse per word

            if (restart) begin
                bytePhase <= takeByte; // First byte may come with the rising edge
            end else if (takeByte) begin
                bytePhase <= !bytePhase;
            end

            // Step on the edge where the pending write lands
            if (restart) begin
                wordIndex <= '0;
            end else if (writeEn) begin
                wordIndex <= wordIndex + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn && takeByte && !highByte) begin
            lowByte <= flashByte;
        end
        if (clkEn && highByte) begin
            writeData <= {flashByte, lowByte};   // Low byte arrived first
        end
    end

    assign flashWrite.en        = writeEn;
    assign flashWrite.wordIndex = wordIndex;
    assign flashWrite.data      = writeData;

    // Held one cycle past flashEn so the last word is in before any read
    assign flashBusy = flashEn || flashEnQ;

endmodule : flashProgrammer

//--- source/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
    parameter int memDepth = 512
) (
    input  logic            clk,
    input  logic            clkEn,
    input  memPkg::memWrite flashWrite,
    input  memPkg::memWrite storeWrite,
    input  logic            readEn,
    input  memPkg::byteAddr readIndex,     // Word index, not a byte address
    output memPkg::dataWord readWord
);
    import memPkg::*;

    localparam int indexBits = (memDepth > 1) ? $clog2(memDepth) : 1;

    dataWord mem [memDepth];
    memWrite selWrite;

    // Flash owns the port while both ask
    assign selWrite = flashWrite.en ? flashWrite : storeWrite;

    always_ff @(posedge clk) begin
        if (clkEn && selWrite.en) begin
            mem[selWrite.wordIndex[indexBits-1:0]] <= selWrite.data;
        end
    end

    // Registered read, one clock of latency
    always_ff @(posedge clk) begin
        if (clkEn && readEn) begin
            readWord <= mem[readIndex[indexBits-1:0]];
        end
    end

    // Flash and the load/store unit must never write in the same cycle
    assert property (@(posedge clk) flashWrite.en |-> !storeWrite.en)
        else $error("dataMemory: flash and store write together");

    assert property (@(posedge clk) clkEn && selWrite.en |-> selWrite.wordIndex < memDepth)
        else $error("dataMemory: write index %0d out of range", selWrite.wordIndex);

    assert property (@(posedge clk) clkEn && readEn |-> readIndex < memDepth)
        else $error("dataMemory: read index %0d out of range", readIndex);

endmodule : dataMemory

//--- source/memPkg.sv
package memPkg;

    typedef logic [15:0] dataWord;     // One memory or register word
    typedef logic [15:0] byteAddr;     // Bit 0 picks the byte in a word
    typedef logic [3:0]  regAddr;      // Destination register number

    // Bit 2 marks a store, bit 0 marks word size
    typedef enum logic [3:0] {
        loadByte  = 4'b0000,
        loadWord  = 4'b0001,
        storeByte = 4'b0100,
        storeWord = 4'b0101
    } minorOp;

    // One operation from the issue stage
    typedef struct packed {
        minorOp  op;
        regAddr  destReg;
        byteAddr addr;
        dataWord data;
    } lsRequest;

    // Load result towards register writeback
    typedef struct packed {
        regAddr  destReg;
        dataWord data;
    } wbResult;

    // One write into data memory
    typedef struct packed {
        logic        en;
        logic [15:0] wordIndex;       // Narrowed to the memory depth
        dataWord     data;
    } memWrite;

endpackage : memPkg
